// ==== filelist.f ====
+incdir+tests
hw/datapathPkg.sv
hw/programCounter.sv
hw/registerFile.sv
hw/alu.sv
hw/datapath.sv
tests/datapathTb.sv

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input wire datapathPkg::aluOpT op,
    input wire [datapathPkg::DataWidth-1:0] a,
    input wire [datapathPkg::DataWidth-1:0] b,
    output logic [2*datapathPkg::DataWidth-1:0] result,
    output datapathPkg::aluFlagsT flags
);

    import datapathPkg::*;

    localparam int ShiftWidth = $clog2(DataWidth);

    logic [ShiftWidth-1:0] shamt;
    logic [2*DataWidth-1:0] doubledA;
    logic [2*DataWidth-1:0] rotLeft;
    logic [2*DataWidth-1:0] rotRight;
    logic signed [2*DataWidth-1:0] product;
    logic [DataWidth-1:0] lowHalf;

    // Shift amount is the low bits of B
    assign shamt = b[ShiftWidth-1:0];

    // Rotates by shifting A concatenated with itself
    assign doubledA = {a, a};
    assign rotLeft = doubledA << shamt;
    assign rotRight = doubledA >> shamt;

    // Full signed product of the operands sign-extended to 64 bits
    assign product = $signed({{DataWidth{a[DataWidth-1]}}, a})
                   * $signed({{DataWidth{b[DataWidth-1]}}, b});

    always_comb begin
        result = '0;
        unique case (op)
            AluAdd: begin
                result[DataWidth-1:0] = a + b;
            end
            AluSub: begin
                result[DataWidth-1:0] = a - b;
            end
            AluAnd: begin
                result[DataWidth-1:0] = a & b;
            end
            AluOr: begin
                result[DataWidth-1:0] = a | b;
            end
            AluShl: begin
                result[DataWidth-1:0] = a << shamt;
            end
            AluShr: begin
                // Logical shift with zero fill
                result[DataWidth-1:0] = a >> shamt;
            end
            AluRol: begin
                result[DataWidth-1:0] = rotLeft[2*DataWidth-1:DataWidth];
            end
            AluRor: begin
                result[DataWidth-1:0] = rotRight[DataWidth-1:0];
            end
            AluNeg: begin
                result[DataWidth-1:0] = ~b + DataWidth'(1);
            end
            AluNot: begin
                result[DataWidth-1:0] = ~b;
            end
            AluMul: begin
                result = product;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Flags describe the low half only
    assign lowHalf = result[DataWidth-1:0];
    assign flags.zero = (lowHalf == '0);
    assign flags.neg = lowHalf[DataWidth-1];

endmodule

`default_nettype wire

// ==== hw/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter logic [datapathPkg::DataWidth-1:0] ResetPc = '0
) (
    input wire Clock,
    input wire rstN,
    input wire datapathPkg::datapathCtrlT ctrl,
    input wire [datapathPkg::DataWidth-1:0] memData,
    output logic [datapathPkg::DataWidth-1:0] memAddr,
    output logic [datapathPkg::DataWidth-1:0] storeData,
    output datapathPkg::aluFlagsT aluFlags,
    output datapathPkg::condFlagsT condFlags
);

    import datapathPkg::*;

    logic [DataWidth-1:0] pc;
    logic [DataWidth-1:0] portA;
    logic [DataWidth-1:0] portB;

    // ALU operand registers
    logic [DataWidth-1:0] regA;
    logic [DataWidth-1:0] regB;
    logic [DataWidth-1:0] bOperand;

    // Result halves, store data and write-back
    logic [2*DataWidth-1:0] aluResult;
    logic [DataWidth-1:0] rzHigh;
    logic [DataWidth-1:0] rzLow;
    logic [DataWidth-1:0] rasReg;
    logic [DataWidth-1:0] rwbReg;
    logic [DataWidth-1:0] aluSource;
    logic [DataWidth-1:0] wbSource;

    programCounter #(
        .ResetPc(ResetPc)
    ) i_programCounter (
        .Clock (Clock),
        .rstN  (rstN),
        .clear (ctrl.pcClear),
        .en    (ctrl.pcEn),
        .mode  (ctrl.pcMode),
        .offset(ctrl.imm32),
        .target(portA),
        .pc    (pc)
    );

    // Write port fed from the write-back register
    registerFile i_registerFile (
        .Clock    (Clock),
        .write    (ctrl.rfWrite),
        .addrA    (ctrl.addrA),
        .addrB    (ctrl.addrB),
        .addrC    (ctrl.addrC),
        .writeData(rwbReg),
        .portA    (portA),
        .portB    (portB)
    );

    // Immediate replaces the B register when selected
    assign bOperand = ctrl.bImmSel ? ctrl.imm32 : regB;

    alu i_alu (
        .op    (ctrl.aluOp),
        .a     (regA),
        .b     (bOperand),
        .result(aluResult),
        .flags (aluFlags)
    );

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            regA <= '0;
            regB <= '0;
        end else begin
            if (ctrl.raEn) begin
                regA <= portA;
            end
            if (ctrl.rbEn) begin
                regB <= portB;
            end
        end
    end

    // Both halves load together
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            rzHigh <= '0;
            rzLow <= '0;
        end else if (ctrl.rzEn) begin
            rzHigh <= aluResult[2*DataWidth-1:DataWidth];
            rzLow <= aluResult[DataWidth-1:0];
        end
    end

    // Store data taken straight from port B
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            rasReg <= '0;
        end else if (ctrl.rasEn) begin
            rasReg <= portB;
        end
    end

    // High half only matters after a multiply
    assign aluSource = ctrl.rzHighSel ? rzHigh : rzLow;

    always_comb begin
        unique case (ctrl.wbSel)
            WbAlu:   wbSource = aluSource;
            WbMem:   wbSource = memData;
            WbPc:    wbSource = pc;
            default: wbSource = aluSource;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            rwbReg <= '0;
        end else if (ctrl.wbEn) begin
            rwbReg <= wbSource;
        end
    end

    // Fetch uses the PC, loads and stores use the ALU low half
    assign memAddr = ctrl.memAddrPcSel ? pc : rzLow;
    assign storeData = rasReg;

    // Branch conditions on the register at port A
    assign condFlags.zero = (portA == '0);
    assign condFlags.nonZero = (portA != '0);
    assign condFlags.neg = portA[DataWidth-1];
    assign condFlags.pos = !portA[DataWidth-1] && (portA != '0);

endmodule

`default_nettype wire

// ==== hw/datapathPkg.sv ====
`default_nettype none

package datapathPkg;

    // Word and register index widths fixed by the instruction format
    parameter int DataWidth = 32;
    parameter int RegAddrWidth = 4;

    // ALU operations
    typedef enum logic [3:0] {
        AluAdd = 4'd0,
        AluSub = 4'd1,
        AluAnd = 4'd2,
        AluOr  = 4'd3,
        AluShl = 4'd4,
        AluShr = 4'd5,
        AluRol = 4'd6,
        AluRor = 4'd7,
        AluNeg = 4'd8,
        AluNot = 4'd9,
        AluMul = 4'd10
    } aluOpT;

    // Program counter update choices
    typedef enum logic [1:0] {
        PcInc = 2'd0,
        PcRel = 2'd1,
        PcReg = 2'd2
    } pcModeT;

    // Write-back register sources
    typedef enum logic [1:0] {
        WbAlu = 2'd0,
        WbMem = 2'd1,
        WbPc  = 2'd2
    } wbSelT;

    // Control word from the control unit, one per cycle
    typedef struct packed {
        logic pcClear;
        logic pcEn;
        pcModeT pcMode;
        logic rfWrite;
        logic [RegAddrWidth-1:0] addrA;
        logic [RegAddrWidth-1:0] addrB;
        logic [RegAddrWidth-1:0] addrC;
        logic raEn;
        logic rbEn;
        logic bImmSel;
        aluOpT aluOp;
        logic rzEn;
        logic rzHighSel;
        logic rasEn;
        logic wbEn;
        wbSelT wbSel;
        logic memAddrPcSel;
        logic [DataWidth-1:0] imm32;
    } datapathCtrlT;

    // Flags of the ALU result low half
    typedef struct packed {
        logic zero;
        logic neg;
    } aluFlagsT;

    // Branch conditions taken from register port A
    typedef struct packed {
        logic zero;
        logic nonZero;
        logic pos;
        logic neg;
    } condFlagsT;

endpackage

`default_nettype wire

// ==== hw/programCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module programCounter #(
    parameter logic [datapathPkg::DataWidth-1:0] ResetPc = '0
) (
    input wire Clock,
    input wire rstN,
    input wire clear,
    input wire en,
    input wire datapathPkg::pcModeT mode,
    input wire [datapathPkg::DataWidth-1:0] offset,
    input wire [datapathPkg::DataWidth-1:0] target,
    output logic [datapathPkg::DataWidth-1:0] pc
);

    import datapathPkg::*;

    logic [DataWidth-1:0] nextPc;
    logic [DataWidth-1:0] pcPlusOne;

    assign pcPlusOne = pc + DataWidth'(1);

    // Next address for each update kind
    always_comb begin
        unique case (mode)
            PcInc:   nextPc = pcPlusOne;
            // Branch offsets are relative to the incremented PC
            PcRel:   nextPc = pcPlusOne + offset;
            PcReg:   nextPc = target;
            default: nextPc = pcPlusOne;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pc <= ResetPc;
        end else if (clear) begin
            pc <= '0;
        end else if (en) begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// ==== hw/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input wire Clock,
    input wire write,
    input wire [datapathPkg::RegAddrWidth-1:0] addrA,
    input wire [datapathPkg::RegAddrWidth-1:0] addrB,
    input wire [datapathPkg::RegAddrWidth-1:0] addrC,
    input wire [datapathPkg::DataWidth-1:0] writeData,
    output logic [datapathPkg::DataWidth-1:0] portA,
    output logic [datapathPkg::DataWidth-1:0] portB
);

    import datapathPkg::*;

    localparam int NumRegs = 2 ** RegAddrWidth;

    // General registers, contents undefined until written
    logic [DataWidth-1:0] regs [NumRegs];

    // Single write port
    always_ff @(posedge Clock) begin
        if (write) begin
            regs[addrC] <= writeData;
        end
    end

    // Asynchronous reads, a write shows up after the edge
    assign portA = regs[addrA];
    assign portB = regs[addrB];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

buildDir=build
logFile=sim.log
simBinary=simDatapath

verilator --binary --timing \
    -f filelist.f \
    --top-module datapathTb \
    -Mdir "$buildDir" \
    -o "$simBinary"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/$simBinary" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

# The log decides pass or fail
if grep -q "Simulation PASSED" "$logFile"; then
    exit 0
fi

echo "Pass message not found in $logFile"
exit 1

// ==== tests/datapathTbTable.svh ====
`ifndef DATAPATH_TB_TABLE_SVH
`define DATAPATH_TB_TABLE_SVH

// Columns: opcode, source A, source B, destination, immediate select, immediate,
// A operand kind (0 random, 1 zero, 2 negative)
typedef struct packed {
    aluOpT op;
    logic [3:0] srcA;
    logic [3:0] srcB;
    logic [3:0] dest;
    logic immSel;
    logic [31:0] imm;
    logic [1:0] aKind;
} rowT;

localparam int NumRows = 19;

rowT rows [NumRows];

task automatic fillTable();
    rows[0]  = '{AluAdd, 4'd1,  4'd2,  4'd3,  1'b0, 32'h0000_0000, 2'd0};
    rows[1]  = '{AluSub, 4'd4,  4'd6,  4'd8,  1'b0, 32'h0000_0000, 2'd0};
    // Same register on both ports gives a zero result
    rows[2]  = '{AluSub, 4'd2,  4'd2,  4'd9,  1'b0, 32'h0000_0000, 2'd0};
    rows[3]  = '{AluAnd, 4'd3,  4'd11, 4'd12, 1'b0, 32'h0000_0000, 2'd0};
    rows[4]  = '{AluOr,  4'd13, 4'd14, 4'd15, 1'b0, 32'h0000_0000, 2'd0};
    rows[5]  = '{AluShl, 4'd1,  4'd2,  4'd0,  1'b0, 32'h0000_0000, 2'd0};
    rows[6]  = '{AluShr, 4'd5,  4'd6,  4'd7,  1'b0, 32'h0000_0000, 2'd2};
    rows[7]  = '{AluRol, 4'd8,  4'd9,  4'd10, 1'b0, 32'h0000_0000, 2'd0};
    rows[8]  = '{AluRor, 4'd10, 4'd11, 4'd1,  1'b0, 32'h0000_0000, 2'd0};
    // NEG of R7 into R5
    rows[9]  = '{AluNeg, 4'd7,  4'd7,  4'd5,  1'b0, 32'h0000_0000, 2'd0};
    rows[10] = '{AluNot, 4'd2,  4'd3,  4'd4,  1'b0, 32'h0000_0000, 2'd1};
    rows[11] = '{AluMul, 4'd6,  4'd7,  4'd8,  1'b0, 32'h0000_0000, 2'd2};
    rows[12] = '{AluMul, 4'd9,  4'd10, 4'd11, 1'b0, 32'h0000_0000, 2'd0};
    rows[13] = '{AluAdd, 4'd1,  4'd0,  4'd2,  1'b1, 32'h0000_0100, 2'd0};
    rows[14] = '{AluSub, 4'd3,  4'd0,  4'd4,  1'b1, 32'hffff_fff0, 2'd1};
    rows[15] = '{AluShl, 4'd5,  4'd0,  4'd6,  1'b1, 32'h0000_0024, 2'd0};
    rows[16] = '{AluAnd, 4'd12, 4'd0,  4'd13, 1'b1, 32'h0000_ffff, 2'd0};
    rows[17] = '{AluOr,  4'd14, 4'd0,  4'd15, 1'b1, 32'h8000_0000, 2'd1};
    rows[18] = '{AluNeg, 4'd0,  4'd0,  4'd1,  1'b1, 32'h0000_0000, 2'd0};
endtask

`endif

// ==== tests/datapathTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapathTb;

    import datapathPkg::*;

    `include "datapathTbTable.svh"

    localparam int ClockPeriod = 8;
    localparam int TimeoutNs = NumRows * 20 * ClockPeriod + 200;

    logic Clock;
    logic rstN;
    datapathCtrlT ctrl;
    logic [DataWidth-1:0] memData;
    logic [DataWidth-1:0] memAddr;
    logic [DataWidth-1:0] storeData;
    aluFlagsT aluFlags;
    condFlagsT condFlags;
    int errors;
    int checks;

    datapath #(
        .ResetPc('0)
    ) i_datapath (
        .Clock    (Clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .memData  (memData),
        .memAddr  (memAddr),
        .storeData(storeData),
        .aluFlags (aluFlags),
        .condFlags(condFlags)
    );

    always #(ClockPeriod / 2) Clock = ~Clock;

    // Expected 64-bit ALU result
    function automatic logic [63:0] aluModel(aluOpT op, logic [31:0] a, logic [31:0] b);
        logic [5:0] s;
        logic [63:0] res;
        s = {1'b0, b[4:0]};
        res = '0;
        case (op)
            AluAdd: res[31:0] = a + b;
            AluSub: res[31:0] = a - b;
            AluAnd: res[31:0] = a & b;
            AluOr:  res[31:0] = a | b;
            AluShl: res[31:0] = a << s;
            AluShr: res[31:0] = a >> s;
            AluRol: res[31:0] = (s == 6'd0) ? a : ((a << s) | (a >> (6'd32 - s)));
            AluRor: res[31:0] = (s == 6'd0) ? a : ((a >> s) | (a << (6'd32 - s)));
            AluNeg: res[31:0] = 32'd0 - b;
            AluNot: res[31:0] = ~b;
            AluMul: res = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            default: res = '0;
        endcase
        return res;
    endfunction

    // New control word shortly after the rising edge
    task automatic drive(input datapathCtrlT w);
        @(posedge Clock);
        #1;
        ctrl = w;
    endtask

    // One idle cycle sampled in the middle
    task automatic settle(input logic pcSel);
        datapathCtrlT w;
        w = '0;
        w.memAddrPcSel = pcSel;
        drive(w);
        @(negedge Clock);
    endtask

    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Memory data goes into RWB and then into the register file
    task automatic loadRegister(input logic [3:0] index, input logic [31:0] value);
        datapathCtrlT w;
        w = '0;
        w.wbEn = 1'b1;
        w.wbSel = WbMem;
        drive(w);
        memData = value;
        w = '0;
        w.rfWrite = 1'b1;
        w.addrC = index;
        drive(w);
    endtask

    // Write back one result half to dest and read it out through RAS
    task automatic readBack(input logic [3:0] dest, input logic high);
        datapathCtrlT w;
        w = '0;
        w.wbEn = 1'b1;
        w.wbSel = WbAlu;
        w.rzHighSel = high;
        drive(w);
        w = '0;
        w.rfWrite = 1'b1;
        w.addrC = dest;
        drive(w);
        w = '0;
        w.rasEn = 1'b1;
        w.addrB = dest;
        drive(w);
        settle(1'b0);
    endtask

    task automatic checkProgramCounter();
        datapathCtrlT w;
        settle(1'b0);
        checkValue("RZL after reset", memAddr, 32'd0);
        checkValue("RAS after reset", storeData, 32'd0);
        settle(1'b1);
        checkValue("pc after reset", memAddr, 32'd0);
        w = '0;
        w.pcEn = 1'b1;
        w.pcMode = PcInc;
        repeat (3) drive(w);
        settle(1'b1);
        checkValue("pc after three increments", memAddr, 32'd3);
        w.pcMode = PcRel;
        w.imm32 = 32'h0000_0010;
        drive(w);
        settle(1'b1);
        checkValue("pc after relative branch", memAddr, 32'd20);
        loadRegister(4'd9, 32'h0000_0400);
        w = '0;
        w.pcEn = 1'b1;
        w.pcMode = PcReg;
        w.addrA = 4'd9;
        drive(w);
        settle(1'b1);
        checkValue("pc after register jump", memAddr, 32'h0000_0400);
        // PC goes through RWB into R10 and out through RAS
        w = '0;
        w.wbEn = 1'b1;
        w.wbSel = WbPc;
        drive(w);
        w = '0;
        w.rfWrite = 1'b1;
        w.addrC = 4'd10;
        drive(w);
        w = '0;
        w.rasEn = 1'b1;
        w.addrB = 4'd10;
        drive(w);
        settle(1'b0);
        checkValue("pc write-back", storeData, 32'h0000_0400);
        w = '0;
        w.pcClear = 1'b1;
        drive(w);
        settle(1'b1);
        checkValue("pc after clear", memAddr, 32'd0);
    endtask

    task automatic runRow(input int idx);
        rowT r;
        datapathCtrlT w;
        condFlagsT expCond;
        logic [31:0] valA;
        logic [31:0] valB;
        logic [63:0] expected;
        string tag;
        r = rows[idx];
        tag = $sformatf("row %0d", idx);
        valA = $urandom();
        valB = $urandom();
        if (r.aKind == 2'd1)
            valA = '0;
        else if (r.aKind == 2'd2)
            valA[31] = 1'b1;
        if (r.srcA == r.srcB)
            valB = valA;
        loadRegister(r.srcA, valA);
        if (r.srcA != r.srcB)
            loadRegister(r.srcB, valB);
        expected = aluModel(r.op, valA, r.immSel ? r.imm : valB);
        expCond.zero = (valA == 32'd0);
        expCond.nonZero = !expCond.zero;
        expCond.pos = ($signed(valA) > 0);
        expCond.neg = ($signed(valA) < 0);
        w = '0;
        w.addrA = r.srcA;
        drive(w);
        @(negedge Clock);
        checkValue({tag, " condFlags"}, {28'd0, condFlags}, {28'd0, expCond});
        w.addrB = r.srcB;
        w.raEn = 1'b1;
        w.rbEn = 1'b1;
        drive(w);
        w = '0;
        w.aluOp = r.op;
        w.bImmSel = r.immSel;
        w.imm32 = r.imm;
        w.rzEn = 1'b1;
        drive(w);
        @(negedge Clock);
        checkValue({tag, " aluFlags"}, {30'd0, aluFlags},
                   {30'd0, (expected[31:0] == 32'd0), expected[31]});
        // RZL is now loaded and visible on the address path
        settle(1'b0);
        checkValue({tag, " memAddr"}, memAddr, expected[31:0]);
        readBack(r.dest, 1'b0);
        checkValue({tag, " low half"}, storeData, expected[31:0]);
        if (r.op == AluMul) begin
            readBack(r.dest, 1'b1);
            checkValue({tag, " high half"}, storeData, expected[63:32]);
        end
    endtask

    initial begin
        Clock = 1'b0;
        rstN = 1'b0;
        ctrl = '0;
        memData = '0;
        errors = 0;
        checks = 0;
        void'($urandom(32'h22fd_cdcc));
        fillTable();
        repeat (2) @(posedge Clock);
        #1;
        rstN = 1'b1;
        checkProgramCounter();
        for (int i = 0; i < NumRows; i++) begin
            runRow(i);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TimeoutNs);
        $display("Timeout: the tests did not finish within %0d ns", TimeoutNs);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
